/* design/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// width of every byte address and pc in the front end
`define FETCH_ADDR_W 64

// instruction memory depth in 32-bit words, 4 KiB total
`define FETCH_IMEM_WORDS 1024

// entries between fetch and decode
`define FETCH_QUEUE_DEPTH 4

// byte address of the first fetch after reset
`define FETCH_RESET_PC 0

`endif

/* design/fetch_pkg.sv */
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

  // byte address, also used for pc and branch targets
  typedef logic [`FETCH_ADDR_W-1:0] addr_t;

  // raw a64 instruction word
  typedef logic [31:0] insn_t;

  // sign-extended offset out of predecode
  typedef logic [`FETCH_ADDR_W-1:0] imm_t;

  // predecode classes, only what next-pc and target logic care about
  typedef enum logic [2:0] {
    OP_OTHER,
    OP_B,
    OP_BL,
    OP_B_COND,
    OP_ADR,
    OP_ADRP
  } opcode_t;

endpackage

`default_nettype wire

/* design/fetch_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface fetch_bus;

  // handshake, transfer when both high on a rising edge
  logic valid;
  logic ready;

  // payload of one fetched instruction
  fetch_pkg::insn_t   insn;
  fetch_pkg::addr_t   pc;
  fetch_pkg::addr_t   target;
  fetch_pkg::opcode_t kind;

  // producer side, holds payload while stalled
  modport src (output valid, insn, pc, target, kind, input ready);

  // consumer side
  modport dst (input valid, insn, pc, target, kind, output ready);

endinterface

`default_nettype wire

/* design/inst_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module inst_mem (
  input  wire                   in_clk,
  input  wire                   prog_we,
  input  wire fetch_pkg::addr_t prog_addr,
  input  wire fetch_pkg::insn_t prog_data,
  input  wire fetch_pkg::addr_t addr,
  output fetch_pkg::insn_t      data
);

  localparam int IDX_W = $clog2(`FETCH_IMEM_WORDS);

  fetch_pkg::insn_t mem [`FETCH_IMEM_WORDS];

  // word index, upper address bits dropped so the space wraps
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;

  assign rd_idx = addr[IDX_W+1:2];
  assign wr_idx = prog_addr[IDX_W+1:2];

  // program load port, only used while the core is held in reset
  always_ff @(posedge in_clk) begin
    if (prog_we) begin
      mem[wr_idx] <= prog_data;
    end
  end

  // combinational read so fetch sees the word in the same cycle
  assign data = mem[rd_idx];

  // fetch must never present a misaligned pc
  a_addr_aligned: assert property (@(posedge in_clk) addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/predecode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module predecode (
  input  wire fetch_pkg::insn_t insn,
  output fetch_pkg::opcode_t    kind,
  output fetch_pkg::imm_t       imm
);

  // b / bl: op[31] then 00101, imm26 in [25:0]
  logic is_b;
  logic is_bl;
  // b.cond: 0101010 0, imm19 in [23:5], bit 4 clear
  logic is_b_cond;
  // adr / adrp: op[31], immlo [30:29], 10000 in [28:24]
  logic is_adr;
  logic is_adrp;

  // sign-extended immediates per encoding
  fetch_pkg::imm_t imm_br26;
  fetch_pkg::imm_t imm_br19;
  fetch_pkg::imm_t imm_adr21;

  assign is_b      = (insn[31:26] == 6'b000101);
  assign is_bl     = (insn[31:26] == 6'b100101);
  assign is_b_cond = (insn[31:24] == 8'b01010100) && !insn[4];
  assign is_adr    = !insn[31] && (insn[28:24] == 5'b10000);
  assign is_adrp   = insn[31] && (insn[28:24] == 5'b10000);

  // word offsets, scaled to bytes
  assign imm_br26 = {{(`FETCH_ADDR_W-28){insn[25]}}, insn[25:0], 2'b00};
  assign imm_br19 = {{(`FETCH_ADDR_W-21){insn[23]}}, insn[23:5], 2'b00};

  // immhi:immlo, unscaled here, adrp page shift is applied in fetch_pc
  assign imm_adr21 = {{(`FETCH_ADDR_W-21){insn[23]}}, insn[23:5], insn[30:29]};

  always_comb begin
    kind = fetch_pkg::OP_OTHER;
    imm  = '0;
    // encodings are disjoint so order only matters for readability
    if (is_b) begin
      kind = fetch_pkg::OP_B;
      imm  = imm_br26;
    end else if (is_bl) begin
      kind = fetch_pkg::OP_BL;
      imm  = imm_br26;
    end else if (is_b_cond) begin
      kind = fetch_pkg::OP_B_COND;
      imm  = imm_br19;
    end else if (is_adr) begin
      kind = fetch_pkg::OP_ADR;
      imm  = imm_adr21;
    end else if (is_adrp) begin
      kind = fetch_pkg::OP_ADRP;
      imm  = imm_adr21;
    end
  end

endmodule

`default_nettype wire

/* design/fetch_pc.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_pc (
  input  wire                     in_clk,
  input  wire                     in_rst,
  input  wire                     redirect,
  input  wire fetch_pkg::addr_t   redirect_pc,
  output fetch_pkg::addr_t        mem_addr,
  input  wire fetch_pkg::insn_t   mem_data,
  input  wire fetch_pkg::opcode_t kind,
  input  wire fetch_pkg::imm_t    imm,
  fetch_bus.src                   out
);

  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t next_pc;
  fetch_pkg::addr_t target;
  fetch_pkg::addr_t page_base;

  // output register is free, or drains this edge
  logic advance;

  assign advance  = !out.valid || out.ready;
  assign mem_addr = pc_q;

  // 4 KiB page of the current pc, used by adrp
  assign page_base = {pc_q[`FETCH_ADDR_W-1:12], 12'h000};

  // static prediction, unconditional branches taken, rest fall through
  always_comb begin
    case (kind)
      fetch_pkg::OP_B,
      fetch_pkg::OP_BL: next_pc = pc_q + imm;
      default:          next_pc = pc_q + 64'd4;
    endcase
  end

  // address carried downstream for branch resolve and adr/adrp writeback
  always_comb begin
    case (kind)
      fetch_pkg::OP_B_COND,
      fetch_pkg::OP_ADR:  target = pc_q + imm;
      fetch_pkg::OP_ADRP: target = page_base + (imm << 12);
      default:            target = '0;
    endcase
  end

  // control state, redirect wins over everything
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      pc_q      <= fetch_pkg::addr_t'(`FETCH_RESET_PC);
      out.valid <= 1'b0;
    end else if (redirect) begin
      pc_q      <= redirect_pc;
      out.valid <= 1'b0;
    end else if (advance) begin
      pc_q      <= next_pc;
      out.valid <= 1'b1;
    end
  end

  // payload, captured together with the pc advance
  always_ff @(posedge in_clk) begin
    if (advance) begin
      out.insn   <= mem_data;
      out.pc     <= pc_q;
      out.target <= target;
      out.kind   <= kind;
    end
  end

  // a stalled item stays put until the queue takes it or a redirect kills it
  a_src_stable: assert property (@(posedge in_clk) disable iff (in_rst)
    out.valid && !out.ready && !redirect |=>
      out.valid && $stable(out.insn) && $stable(out.pc) &&
      $stable(out.target) && $stable(out.kind));

  // predicted and redirected pcs are always word addresses
  a_pc_aligned: assert property (@(posedge in_clk) disable iff (in_rst)
    pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/fetch_queue.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_queue (
  input  wire                 in_clk,
  input  wire                 in_rst,
  input  wire                 flush,
  fetch_bus.dst               in,
  output logic                valid,
  input  wire                 ready,
  output fetch_pkg::insn_t    insn,
  output fetch_pkg::addr_t    pc,
  output fetch_pkg::addr_t    target,
  output fetch_pkg::opcode_t  kind
);

  localparam int DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

  // storage, one array per field
  fetch_pkg::insn_t   insn_mem   [DEPTH];
  fetch_pkg::addr_t   pc_mem     [DEPTH];
  fetch_pkg::addr_t   target_mem [DEPTH];
  fetch_pkg::opcode_t kind_mem   [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in.ready = (count != FULL);
  assign valid    = (count != '0);
  assign push     = in.valid && in.ready;
  assign pop      = valid && ready;

  // head entry shown combinationally, valid follows the registered count
  assign insn   = insn_mem[rd_ptr];
  assign pc     = pc_mem[rd_ptr];
  assign target = target_mem[rd_ptr];
  assign kind   = kind_mem[rd_ptr];

  // pointers and count, flush drops everything including a same-edge push
  always_ff @(posedge in_clk) begin
    if (in_rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge in_clk) begin
    if (push) begin
      insn_mem[wr_ptr]   <= in.insn;
      pc_mem[wr_ptr]     <= in.pc;
      target_mem[wr_ptr] <= in.target;
      kind_mem[wr_ptr]   <= in.kind;
    end
  end

  a_count_bound: assert property (@(posedge in_clk) disable iff (in_rst)
    count <= FULL);

  // read pointer moves only on a pop from a non-empty queue or on flush
  a_no_empty_pop: assert property (@(posedge in_clk) disable iff (in_rst)
    !$past(flush) && (rd_ptr != $past(rd_ptr)) |-> $past(count) != '0);

endmodule

`default_nettype wire

/* design/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  wire                     in_clk,
  input  wire                     in_rst,
  input  wire                     prog_we,
  input  wire fetch_pkg::addr_t   prog_addr,
  input  wire fetch_pkg::insn_t   prog_data,
  input  wire                     redirect,
  input  wire fetch_pkg::addr_t   redirect_pc,
  output logic                    dec_valid,
  input  wire                     dec_ready,
  output fetch_pkg::insn_t        dec_insn,
  output fetch_pkg::addr_t        dec_pc,
  output fetch_pkg::addr_t        dec_target,
  output fetch_pkg::opcode_t      dec_kind
);

  fetch_pkg::addr_t   mem_addr;
  fetch_pkg::insn_t   mem_data;
  fetch_pkg::opcode_t pre_kind;
  fetch_pkg::imm_t    pre_imm;

  // fetch_pc to queue
  fetch_bus fbus_i ();

  inst_mem imem_i (
    .in_clk    (in_clk),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .addr      (mem_addr),
    .data      (mem_data)
  );

  predecode pre_i (
    .insn (mem_data),
    .kind (pre_kind),
    .imm  (pre_imm)
  );

  fetch_pc pc_i (
    .in_clk      (in_clk),
    .in_rst      (in_rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mem_addr    (mem_addr),
    .mem_data    (mem_data),
    .kind        (pre_kind),
    .imm         (pre_imm),
    .out         (fbus_i.src)
  );

  // a redirect also discards everything already queued
  fetch_queue queue_i (
    .in_clk (in_clk),
    .in_rst (in_rst),
    .flush  (redirect),
    .in     (fbus_i.dst),
    .valid  (dec_valid),
    .ready  (dec_ready),
    .insn   (dec_insn),
    .pc     (dec_pc),
    .target (dec_target),
    .kind   (dec_kind)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk
);

  // 8 ns period
  localparam int HALF_NS = 4;

  initial clk = 1'b0;
  always #HALF_NS clk = ~clk;

endmodule

`default_nettype wire

/* testbench/fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "fetch_defs.svh"

module fetch_tb;

  logic clk;
  logic rst;
  logic prog_we;
  fetch_pkg::addr_t prog_addr;
  fetch_pkg::insn_t prog_data;
  logic redirect;
  fetch_pkg::addr_t redirect_pc;
  logic dec_valid;
  logic dec_ready;
  fetch_pkg::insn_t dec_insn;
  fetch_pkg::addr_t dec_pc;
  fetch_pkg::addr_t dec_target;
  fetch_pkg::opcode_t dec_kind;

  // tb copy of the loaded program and the model pc walking it
  fetch_pkg::insn_t image [`FETCH_IMEM_WORDS];
  fetch_pkg::addr_t m_pc;

  tb_clock clk_i (.clk(clk));

  fetch_top dut_i (
    .in_clk(clk), .in_rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .redirect(redirect), .redirect_pc(redirect_pc),
    .dec_valid(dec_valid), .dec_ready(dec_ready), .dec_insn(dec_insn),
    .dec_pc(dec_pc), .dec_target(dec_target), .dec_kind(dec_kind)
  );

  task automatic fail_and_stop();
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      fail_and_stop();
    end
  endtask

  // test encoders taking offsets in bytes
  function automatic fetch_pkg::insn_t b_word(input bit link, input int off);
    return {link ? 6'b100101 : 6'b000101, 26'(off >>> 2)};
  endfunction

  function automatic fetch_pkg::insn_t bcond_word(input int off, input logic [3:0] cond);
    return {8'b01010100, 19'(off >>> 2), 1'b0, cond};
  endfunction

  // adr counts bytes and adrp counts 4 KiB pages
  function automatic fetch_pkg::insn_t adr_word(input bit page, input int off);
    logic [20:0] v;
    v = 21'(off);
    return {page, v[1:0], 5'b10000, v[20:2], 5'd3};
  endfunction

  // straight-line filler whose top byte keeps it out of every predecoded class
  function automatic fetch_pkg::insn_t fill_word(input int idx);
    return {8'hF9, 4'h0, 10'(idx), 10'(idx ^ 'h2A5)};
  endfunction

  // next expected item by the prediction rule and the step of m_pc
  task automatic model_next(output fetch_pkg::insn_t e_insn, output fetch_pkg::addr_t e_pc,
                            output fetch_pkg::addr_t e_tgt, output fetch_pkg::opcode_t e_kind);
    fetch_pkg::insn_t w;
    longint off;
    fetch_pkg::addr_t nxt;
    w = image[int'((m_pc >> 2) % `FETCH_IMEM_WORDS)];
    e_insn = w;
    e_pc = m_pc;
    e_tgt = '0;
    e_kind = fetch_pkg::OP_OTHER;
    nxt = m_pc + 64'd4;
    casez (w)
      // b and bl differ only in bit 31 and are both predicted taken
      32'b?00101??_????????_????????_????????: begin
        e_kind = w[31] ? fetch_pkg::OP_BL : fetch_pkg::OP_B;
        off = longint'($signed(w[25:0])) * 4;
        nxt = m_pc + fetch_pkg::addr_t'(off);
      end
      32'b01010100_????????_????????_???0????: begin
        e_kind = fetch_pkg::OP_B_COND;
        off = longint'($signed(w[23:5])) * 4;
        e_tgt = m_pc + fetch_pkg::addr_t'(off);
      end
      32'b???10000_????????_????????_????????: begin
        off = longint'($signed({w[23:5], w[30:29]}));
        if (w[31]) begin
          e_kind = fetch_pkg::OP_ADRP;
          e_tgt = ((m_pc >> 12) << 12) + fetch_pkg::addr_t'(off * 4096);
        end else begin
          e_kind = fetch_pkg::OP_ADR;
          e_tgt = m_pc + fetch_pkg::addr_t'(off);
        end
      end
      default: ;
    endcase
    m_pc = nxt;
  endtask

  // accept n items at the dec ports and sample them late in the cycle
  task automatic take_items(input int n, input bit random_ready);
    int got;
    int cycles;
    fetch_pkg::insn_t e_insn;
    fetch_pkg::addr_t e_pc;
    fetch_pkg::addr_t e_tgt;
    fetch_pkg::opcode_t e_kind;
    got = 0;
    cycles = 0;
    while (got < n) begin
      if (cycles > n * 20 + 50) begin
        $display("timeout: only %0d of %0d items reached decode", got, n);
        fail_and_stop();
      end
      dec_ready = random_ready ? (($urandom % 2) == 0) : 1'b1;
      #6;
      if (dec_valid && dec_ready) begin
        model_next(e_insn, e_pc, e_tgt, e_kind);
        check_value("dec_pc", dec_pc, e_pc);
        check_value("dec_insn", 64'(dec_insn), 64'(e_insn));
        check_value("dec_kind", 64'(dec_kind), 64'(e_kind));
        check_value("dec_target", dec_target, e_tgt);
        got++;
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    dec_ready = 1'b0;
  endtask

  // one-cycle redirect pulse with decode stalled
  task automatic redirect_to(input fetch_pkg::addr_t where);
    dec_ready = 1'b0;
    redirect = 1'b1;
    redirect_pc = where;
    @(posedge clk);
    #1;
    redirect = 1'b0;
    m_pc = where;
  endtask

  task automatic build_image();
    for (int i = 0; i < `FETCH_IMEM_WORDS; i++) begin
      image[i] = fill_word(i);
    end
    // 0x000 holds add immediates and no branches
    for (int i = 0; i < 32; i++) begin
      image[i] = 32'h91000421 + 32'(i << 10);
    end
    // 0x100 branch region with forward and backward offsets
    image['h41] = b_word(1'b0, 16);
    image['h45] = b_word(1'b1, 40);
    image['h50] = b_word(1'b0, -32);
    image['h49] = b_word(1'b0, 64);
    // 0x200 target region with both signs
    image['h80] = bcond_word(12, 4'h1);
    image['h81] = bcond_word(-256, 4'hB);
    image['h82] = adr_word(1'b0, 21);
    image['h83] = adr_word(1'b0, -3);
    image['h84] = adr_word(1'b1, 2);
    image['h85] = adr_word(1'b1, -1);
  endtask

  // whole memory written under reset and then the 16-cycle reset tail
  task automatic load_and_reset();
    rst = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < `FETCH_IMEM_WORDS; i++) begin
      prog_we = 1'b1;
      prog_addr = fetch_pkg::addr_t'(i * 4);
      prog_data = image[i];
      @(posedge clk);
      #1;
    end
    prog_we = 1'b0;
    repeat (16) begin
      @(posedge clk);
      #1;
    end
    rst = 1'b0;
    m_pc = fetch_pkg::addr_t'(`FETCH_RESET_PC);
  endtask

  task automatic sequential_stream();
    check_value("dec_valid after reset", 64'(dec_valid), 64'd0);
    take_items(24, 1'b0);
  endtask

  task automatic taken_branches();
    redirect_to(64'h100);
    take_items(10, 1'b0);
  endtask

  task automatic branch_targets();
    redirect_to(64'h200);
    take_items(8, 1'b0);
  endtask

  task automatic random_backpressure();
    redirect_to(64'h400);
    take_items(200, 1'b1);
  endtask

  task automatic redirect_when_full();
    int cycles;
    redirect_to(64'h800);
    cycles = 0;
    while (!dec_valid) begin
      if (cycles >= 20) begin
        $display("timeout: nothing reached decode after redirect to 0x800");
        fail_and_stop();
      end
      @(posedge clk);
      #1;
      cycles++;
    end
    // let the queue and the fetch register fill up
    repeat (8) begin
      @(posedge clk);
      #1;
    end
    check_value("head pc while stalled", dec_pc, 64'h800);
    redirect_to(64'h100);
    // flushed queue shows nothing on the first cycle
    check_value("dec_valid after redirect", 64'(dec_valid), 64'd0);
    take_items(10, 1'b0);
  endtask

  initial begin
    void'($urandom(94));
    rst = 1'b1;
    prog_we = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    dec_ready = 1'b0;
    m_pc = '0;
    build_image();
    load_and_reset();
    sequential_stream();
    taken_branches();
    branch_targets();
    random_backpressure();
    redirect_when_full();
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/fetch_pkg.sv
design/fetch_bus_if.sv
design/inst_mem.sv
design/predecode.sv
design/fetch_pc.sv
design/fetch_queue.sv
design/fetch_top.sv
testbench/tb_clock.sv
testbench/fetch_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module fetch_tb -Mdir obj_dir

# the log decides pass or fail, not the exit status of the run
./obj_dir/Vfetch_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
  exit 0
fi
exit 1
